//--- axi_bram_logger_sva.sv
/*
 * Concurrent assertions on the logger top level, bound to the DUT
 */

`default_nettype none

module axi_bram_logger_sva
  import axi_log_pkg::*;
(
  input logic Clk_CI,
  input logic arst_n,
  input logic rd_en,
  input logic rd_valid,
  input logic clear,
  input logic aw_full,
  input logic ar_full
);
  timeunit 1ns;
  timeprecision 1ps;

  // Cycles since a clear hit a full log, per channel
  logic       aw_pend_q;
  logic       ar_pend_q;
  logic [7:0] aw_wait_q;
  logic [7:0] ar_wait_q;

  always_ff @(posedge Clk_CI or negedge arst_n) begin
    if (!arst_n) begin
      aw_pend_q <= 1'b0;
      ar_pend_q <= 1'b0;
      aw_wait_q <= '0;
      ar_wait_q <= '0;
    end else begin
      if (clear && aw_full) begin
        aw_pend_q <= 1'b1;
        aw_wait_q <= '0;
      end else if (!aw_full) begin
        aw_pend_q <= 1'b0;
      end else if (aw_pend_q) begin
        aw_wait_q <= aw_wait_q + 8'd1;
      end
      if (clear && ar_full) begin
        ar_pend_q <= 1'b1;
        ar_wait_q <= '0;
      end else if (!ar_full) begin
        ar_pend_q <= 1'b0;
      end else if (ar_pend_q) begin
        ar_wait_q <= ar_wait_q + 8'd1;
      end
    end
  end

  // One-cycle read response
  rd_valid_follows_rd_en : assert property (
    @(posedge Clk_CI) disable iff (!arst_n) rd_valid == $past(rd_en))
    else $error("rd_valid is not rd_en delayed by one cycle");

  full_low_in_reset : assert property (
    @(posedge Clk_CI) !arst_n |-> (!aw_full && !ar_full))
    else $error("full flag high during reset");

  // Full must drop before the zero walk could finish twice
  aw_full_falls_after_clear : assert property (
    @(posedge Clk_CI) disable iff (!arst_n) aw_wait_q <= 8'(NUM_ENTRIES + 2))
    else $error("aw_full stays high after clear");

  ar_full_falls_after_clear : assert property (
    @(posedge Clk_CI) disable iff (!arst_n) ar_wait_q <= 8'(NUM_ENTRIES + 2))
    else $error("ar_full stays high after clear");

endmodule

bind axi_bram_logger_top axi_bram_logger_sva u_sva (
  .Clk_CI   (Clk_CI),
  .arst_n   (arst_n),
  .rd_en    (rd_en),
  .rd_valid (rd_valid),
  .clear    (clear),
  .aw_full  (aw_full),
  .ar_full  (ar_full)
);

`default_nettype wire

//--- axi_bram_logger_top.f
axi_log_pkg.sv
log_ram.sv
axi_chan_logger.sv
log_readout.sv
axi_bram_logger_top.sv
axi_bram_logger_sva.sv
tb_axi_bram_logger.sv

//--- axi_bram_logger_top.sv
/*
 * AXI AW/AR transaction logger top level
 */

`default_nettype none

module axi_bram_logger_top
  import axi_log_pkg::*;
(
  input  logic                 Clk_CI,
  input  logic                 arst_n,
  // AW channel
  input  logic                 aw_valid,
  input  logic                 aw_ready,
  input  logic [ID_W-1:0]      aw_id,
  input  logic [ADDR_W-1:0]    aw_addr,
  input  logic [LEN_W-1:0]     aw_len,
  // AR channel
  input  logic                 ar_valid,
  input  logic                 ar_ready,
  input  logic [ID_W-1:0]      ar_id,
  input  logic [ADDR_W-1:0]    ar_addr,
  input  logic [LEN_W-1:0]     ar_len,
  // Control and status
  input  logic                 clear,
  output logic                 aw_full,
  output logic                 ar_full,
  // Software read port
  input  logic                 rd_en,
  input  logic [RD_ADDR_W-1:0] rd_addr,
  output logic [WORD_W-1:0]    rd_data,
  output logic                 rd_valid
);

  logic               aw_rd_en;
  logic               ar_rd_en;
  logic [IDX_W-1:0]   rd_entry_idx;
  logic [ENTRY_W-1:0] aw_entry;
  logic [ENTRY_W-1:0] ar_entry;

  axi_chan_logger u_aw_logger (
    .Clk_CI   (Clk_CI),
    .arst_n   (arst_n),
    .valid    (aw_valid),
    .ready    (aw_ready),
    .id       (aw_id),
    .addr     (aw_addr),
    .len      (aw_len),
    .clear    (clear),
    .full     (aw_full),
    .rd_en    (aw_rd_en),
    .rd_idx   (rd_entry_idx),
    .rd_entry (aw_entry)
  );

  axi_chan_logger u_ar_logger (
    .Clk_CI   (Clk_CI),
    .arst_n   (arst_n),
    .valid    (ar_valid),
    .ready    (ar_ready),
    .id       (ar_id),
    .addr     (ar_addr),
    .len      (ar_len),
    .clear    (clear),
    .full     (ar_full),
    .rd_en    (ar_rd_en),
    .rd_idx   (rd_entry_idx),
    .rd_entry (ar_entry)
  );

  // Shared entry index, enables split by channel
  log_readout u_readout (
    .Clk_CI       (Clk_CI),
    .arst_n       (arst_n),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid),
    .aw_rd_en     (aw_rd_en),
    .ar_rd_en     (ar_rd_en),
    .rd_entry_idx (rd_entry_idx),
    .aw_entry     (aw_entry),
    .ar_entry     (ar_entry)
  );

endmodule

`default_nettype wire

//--- axi_chan_logger.sv
/*
 * Per-channel AXI request logger
 * Control FSM, write and timestamp counters, entry formatting, log memory
 */

`default_nettype none

module axi_chan_logger
  import axi_log_pkg::*;
(
  input  logic               Clk_CI,
  input  logic               arst_n,
  // AXI address channel, observed only
  input  logic               valid,
  input  logic               ready,
  input  logic [ID_W-1:0]    id,
  input  logic [ADDR_W-1:0]  addr,
  input  logic [LEN_W-1:0]   len,
  // Control and status
  input  logic               clear,
  output logic               full,
  // Readout side
  input  logic               rd_en,
  input  logic [IDX_W-1:0]   rd_idx,
  output logic [ENTRY_W-1:0] rd_entry
);

  typedef enum logic [1:0] {
    READY,
    CLEARING,
    FULL
  } state_t;

  state_t             state_q, state_d;
  logic [CNT_W-1:0]   count_q, count_d;
  logic [TS_W-1:0]    ts_q, ts_d;
  logic               accept;
  logic               wr_en;
  logic [ENTRY_W-1:0] wr_data;

  // Handshake seen on the channel
  assign accept = valid & ready;

  // Control FSM
  always_comb begin
    state_d = state_q;
    count_d = count_q;
    wr_en   = 1'b0;
    case (state_q)
      READY: begin
        if (clear) begin
          // Empty log needs no zero walk, only the timestamp restarts
          if (count_q != '0) begin
            state_d = CLEARING;
            count_d = '0;
          end
        end else if (accept) begin
          wr_en   = 1'b1;
          count_d = count_q + 1'b1;
          // Last free entry taken
          if (count_q == CNT_W'(NUM_ENTRIES - 1)) begin
            state_d = FULL;
          end
        end
      end
      CLEARING: begin
        // Counter doubles as the zero-fill index
        wr_en   = 1'b1;
        count_d = count_q + 1'b1;
        if (count_q == CNT_W'(NUM_ENTRIES - 1)) begin
          state_d = READY;
          count_d = '0;
        end
      end
      FULL: begin
        // Requests dropped until cleared
        if (clear) begin
          state_d = CLEARING;
          count_d = '0;
        end
      end
      default: begin
        state_d = READY;
        count_d = '0;
      end
    endcase
  end

  // Early warning, counter is a walk index while clearing
  assign full = (state_q == FULL) ||
                ((state_q == READY) && (count_q >= CNT_W'(NUM_ENTRIES - FULL_MARGIN)));

  // Entry formatting, zeros during the clear walk
  always_comb begin
    wr_data = '0;
    if (state_q != CLEARING) begin
      wr_data[TS_HI:TS_LO]     = ts_q;
      wr_data[ADDR_HI:ADDR_LO] = addr;
      wr_data[LEN_HI:LEN_LO]   = len;
      wr_data[ID_HI:ID_LO]     = id;
    end
  end

  // Free-running timestamp, held at zero while clearing
  assign ts_d = (clear || (state_q == CLEARING)) ? '0 : ts_q + 1'b1;

  always_ff @(posedge Clk_CI or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= READY;
      count_q <= '0;
      ts_q    <= '0;
    end else begin
      state_q <= state_d;
      count_q <= count_d;
      ts_q    <= ts_d;
    end
  end

  log_ram u_log_ram (
    .Clk_CI  (Clk_CI),
    .arst_n  (arst_n),
    .wr_en   (wr_en),
    .wr_idx  (count_q[IDX_W-1:0]),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_idx  (rd_idx),
    .rd_data (rd_entry)
  );

endmodule

`default_nettype wire

//--- axi_log_pkg.sv
/*
 * Shared widths, depths and field positions for the AXI address-channel logger
 */

`default_nettype none

package axi_log_pkg;

  // AXI request fields
  localparam int ID_W            = 8;
  localparam int ADDR_W          = 32;
  localparam int LEN_W           = 8;

  // Log entry format
  localparam int TS_W            = 32;
  localparam int ENTRY_W         = 96;
  localparam int WORD_W          = 32;
  localparam int WORDS_PER_ENTRY = 3;

  // Log depth per channel, kept small so simulation can fill it
  localparam int NUM_ENTRIES     = 64;
  localparam int IDX_W           = 6;
  // Counts 0 up to NUM_ENTRIES inclusive
  localparam int CNT_W           = 7;
  // Free entries left when the full flag rises
  localparam int FULL_MARGIN     = 16;

  // Entry field positions, bits 95:80 stay zero
  localparam int TS_LO           = 0;
  localparam int TS_HI           = 31;
  localparam int ADDR_LO         = 32;
  localparam int ADDR_HI         = 63;
  localparam int LEN_LO          = 64;
  localparam int LEN_HI          = 71;
  localparam int ID_LO           = 72;
  localparam int ID_HI           = 79;

  // Software read address, {chan, entry idx, word idx}
  localparam int RD_ADDR_W       = 9;
  localparam int RD_CHAN_BIT     = 8;
  localparam int RD_IDX_LO       = 2;
  localparam int WORD_IDX_W      = 2;

endpackage

`default_nettype wire

//--- log_ram.sv
/*
 * Inferred simple dual-port log memory
 * One write port, one registered read port
 */

`default_nettype none

module log_ram
  import axi_log_pkg::*;
(
  input  logic               Clk_CI,
  input  logic               arst_n,
  // Write port
  input  logic               wr_en,
  input  logic [IDX_W-1:0]   wr_idx,
  input  logic [ENTRY_W-1:0] wr_data,
  // Read port
  input  logic               rd_en,
  input  logic [IDX_W-1:0]   rd_idx,
  output logic [ENTRY_W-1:0] rd_data
);

  // Storage array
  logic [ENTRY_W-1:0] mem [NUM_ENTRIES];

  // Write port
  always_ff @(posedge Clk_CI) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

  // Registered read, one cycle latency
  // Same-cycle write to the read index returns the old content
  always_ff @(posedge Clk_CI or negedge arst_n) begin
    if (!arst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_idx];
    end
  end

endmodule

`default_nettype wire

//--- log_readout.sv
/*
 * Software readout, 32-bit word port over both channel logs
 */

`default_nettype none

module log_readout
  import axi_log_pkg::*;
(
  input  logic                 Clk_CI,
  input  logic                 arst_n,
  // Software read port
  input  logic                 rd_en,
  input  logic [RD_ADDR_W-1:0] rd_addr,
  output logic [WORD_W-1:0]    rd_data,
  output logic                 rd_valid,
  // Logger side
  output logic                 aw_rd_en,
  output logic                 ar_rd_en,
  output logic [IDX_W-1:0]     rd_entry_idx,
  input  logic [ENTRY_W-1:0]   aw_entry,
  input  logic [ENTRY_W-1:0]   ar_entry
);

  logic                  chan_q;
  logic [WORD_IDX_W-1:0] word_q;
  logic [ENTRY_W-1:0]    entry_sel;

  // Steer the read to one log
  assign aw_rd_en     = rd_en & ~rd_addr[RD_CHAN_BIT];
  assign ar_rd_en     = rd_en & rd_addr[RD_CHAN_BIT];
  assign rd_entry_idx = rd_addr[RD_IDX_LO +: IDX_W];

  // Track channel and word alongside the memory read
  always_ff @(posedge Clk_CI or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid <= 1'b0;
      chan_q   <= 1'b0;
      word_q   <= '0;
    end else begin
      rd_valid <= rd_en;
      if (rd_en) begin
        chan_q <= rd_addr[RD_CHAN_BIT];
        word_q <= rd_addr[WORD_IDX_W-1:0];
      end
    end
  end

  assign entry_sel = chan_q ? ar_entry : aw_entry;

  // Word select, index past the entry reads zero
  always_comb begin
    rd_data = '0;
    if (word_q < WORD_IDX_W'(WORDS_PER_ENTRY)) begin
      rd_data = entry_sel[WORD_W*word_q +: WORD_W];
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the logger testbench with Verilator, fail on the fail message
verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_bram_logger \
  -f axi_bram_logger_top.f -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST OK" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

//--- tb_axi_bram_logger.sv
/*
 * Testbench for the AXI AW/AR logger
 * LFSR traffic, reference model, readback and checks
 */

`default_nettype none

module tb_axi_bram_logger
  import axi_log_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum {M_READY, M_CLEARING, M_FULL} model_state_t;

  logic                 Clk_CI;
  logic                 arst_n;
  logic                 aw_valid, aw_ready, ar_valid, ar_ready;
  logic [ID_W-1:0]      aw_id, ar_id;
  logic [ADDR_W-1:0]    aw_addr, ar_addr;
  logic [LEN_W-1:0]     aw_len, ar_len;
  logic                 clear;
  logic                 aw_full, ar_full;
  logic                 rd_en;
  logic [RD_ADDR_W-1:0] rd_addr;
  logic [WORD_W-1:0]    rd_data;
  logic                 rd_valid;

  // Reference model state, index 0 is AW and 1 is AR
  logic [ENTRY_W-1:0]   m_mem [2][NUM_ENTRIES];
  logic [TS_W-1:0]      m_ts [2];
  int                   m_cnt [2];
  model_state_t         m_state [2];

  logic [31:0]          lfsr;
  int                   cycle_cnt = 0;
  // Outstanding reads, oldest first
  logic [WORD_W-1:0]    exp_q [$];
  logic [RD_ADDR_W-1:0] addr_q [$];
  int                   issue_q [$];

  axi_bram_logger_top UUT (.*);

  initial begin
    Clk_CI = 1'b0;
    forever #10 Clk_CI = ~Clk_CI;
  end

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [ENTRY_W-1:0] got,
                       input logic [ENTRY_W-1:0] exp);
    if (got !== exp) begin
      abort($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // Galois LFSR, one step per random bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // One clock of one channel logger
  task automatic model_step(input int ch, input logic vld, input logic rdy,
                            input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                            input logic [LEN_W-1:0] len, input logic clr);
    model_state_t st;
    st = m_state[ch];
    case (st)
      M_READY: begin
        if (clr) begin
          if (m_cnt[ch] != 0) begin
            m_state[ch] = M_CLEARING;
            m_cnt[ch] = 0;
          end
        end else if (vld && rdy) begin
          // Entry layout: zero, id, len, addr, timestamp
          m_mem[ch][m_cnt[ch]] = {16'h0, id, len, addr, m_ts[ch]};
          m_cnt[ch]++;
          if (m_cnt[ch] == NUM_ENTRIES) m_state[ch] = M_FULL;
        end
      end
      M_CLEARING: begin
        m_mem[ch][m_cnt[ch]] = '0;
        m_cnt[ch]++;
        if (m_cnt[ch] == NUM_ENTRIES) begin
          m_state[ch] = M_READY;
          m_cnt[ch] = 0;
        end
      end
      default: begin
        if (clr) begin
          m_state[ch] = M_CLEARING;
          m_cnt[ch] = 0;
        end
      end
    endcase
    m_ts[ch] = (clr || st == M_CLEARING) ? '0 : m_ts[ch] + 1;
  endtask

  function automatic logic expected_full(input int ch);
    return (m_state[ch] == M_FULL) ||
           (m_state[ch] == M_READY && m_cnt[ch] >= NUM_ENTRIES - FULL_MARGIN);
  endfunction

  // Expected read word for a software address
  function automatic logic [WORD_W-1:0] expected_word(input logic [RD_ADDR_W-1:0] a);
    logic [ENTRY_W-1:0] e;
    e = m_mem[a[8]][a[7:2]];
    case (a[1:0])
      2'd0: return e[31:0];
      2'd1: return e[63:32];
      2'd2: return e[95:64];
      default: return '0;
    endcase
  endfunction

  always @(posedge Clk_CI) begin
    cycle_cnt++;
    if (!arst_n) begin
      for (int ch = 0; ch < 2; ch++) begin
        m_cnt[ch] = 0;
        m_state[ch] = M_READY;
        m_ts[ch] = '0;
      end
    end else begin
      model_step(0, aw_valid, aw_ready, aw_id, aw_addr, aw_len, clear);
      model_step(1, ar_valid, ar_ready, ar_id, ar_addr, ar_len, clear);
    end
  end

  // Compare flags every cycle and each returned read word
  always @(negedge Clk_CI) begin
    if (arst_n) begin
      check("aw_full", aw_full, expected_full(0));
      check("ar_full", ar_full, expected_full(1));
      if (rd_valid) begin
        if (exp_q.size() == 0) abort("rd_valid pulsed with no read outstanding");
        check("rd_latency", cycle_cnt, issue_q.pop_front() + 1);
        check($sformatf("rd_data @0x%03h", addr_q.pop_front()), rd_data, exp_q.pop_front());
      end
    end
  end

  task automatic set_handshake(input logic v);
    aw_valid = v;
    aw_ready = v;
    ar_valid = v;
    ar_ready = v;
  endtask

  // Random request on one channel, valid only when enabled
  task automatic drive_channel(input int ch, input logic en);
    logic v;
    logic r;
    v = 1'(rand_bits(1)) & en;
    r = 1'(rand_bits(1));
    if (ch == 0) begin
      aw_valid = v;
      aw_ready = r;
      aw_id = ID_W'(rand_bits(ID_W));
      aw_addr = rand_bits(ADDR_W);
      aw_len = LEN_W'(rand_bits(LEN_W));
    end else begin
      ar_valid = v;
      ar_ready = r;
      ar_id = ID_W'(rand_bits(ID_W));
      ar_addr = rand_bits(ADDR_W);
      ar_len = LEN_W'(rand_bits(LEN_W));
    end
  endtask

  // Random traffic until both channels hold their target count
  task automatic run_traffic(input int aw_target, input int ar_target);
    int waited;
    waited = 0;
    while (m_cnt[0] < aw_target || m_cnt[1] < ar_target) begin
      @(negedge Clk_CI);
      drive_channel(0, m_cnt[0] < aw_target);
      drive_channel(1, m_cnt[1] < ar_target);
      waited++;
      if (waited > 4000) abort("timeout waiting for accepted requests");
    end
    @(negedge Clk_CI);
    set_handshake(1'b0);
  endtask

  task automatic pulse_clear();
    int waited;
    waited = 0;
    @(negedge Clk_CI);
    set_handshake(1'b0);
    clear = 1'b1;
    @(negedge Clk_CI);
    clear = 1'b0;
    // Zero walk done in the model and both flags down
    while (m_state[0] != M_READY || m_state[1] != M_READY || aw_full || ar_full) begin
      @(negedge Clk_CI);
      waited++;
      if (waited > NUM_ENTRIES + 8) abort("timeout waiting for the clear walk to end");
    end
  endtask

  task automatic issue_read(input logic [RD_ADDR_W-1:0] a);
    @(negedge Clk_CI);
    rd_en = 1'b1;
    rd_addr = a;
    exp_q.push_back(expected_word(a));
    addr_q.push_back(a);
    issue_q.push_back(cycle_cnt);
  endtask

  task automatic drain_reads();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge Clk_CI);
      rd_en = 1'b0;
      waited++;
      if (waited > 8) abort("timeout waiting for rd_valid");
    end
  endtask

  // Every word of both logs, one read at a time
  task automatic sweep_all();
    for (int a = 0; a < 2 ** RD_ADDR_W; a++) begin
      issue_read(RD_ADDR_W'(a));
      drain_reads();
    end
  endtask

  initial begin
    lfsr = 32'h60a0c9d6;
    arst_n = 1'b0;
    clear = 1'b0;
    rd_en = 1'b0;
    rd_addr = '0;
    set_handshake(1'b0);
    {aw_id, aw_addr, aw_len} = '0;
    {ar_id, ar_addr, ar_len} = '0;
    for (int ch = 0; ch < 2; ch++) begin
      for (int i = 0; i < NUM_ENTRIES; i++) m_mem[ch][i] = '0;
    end
    repeat (3) @(posedge Clk_CI);
    @(negedge Clk_CI);
    arst_n = 1'b1;

    // Log array powers up unknown, a write plus clear zero-fills it
    @(negedge Clk_CI);
    set_handshake(1'b1);
    @(negedge Clk_CI);
    set_handshake(1'b0);
    pulse_clear();

    // AR only, AW log stays empty
    run_traffic(0, 10);
    check("aw_full", aw_full, 1'b0);
    sweep_all();

    // Mixed random traffic on both channels
    pulse_clear();
    run_traffic(20, 20);
    sweep_all();

    // Fill AW, then requests past the end are dropped
    run_traffic(NUM_ENTRIES, 20);
    check("aw_full", aw_full, 1'b1);
    repeat (8) begin
      @(negedge Clk_CI);
      drive_channel(0, 1'b1);
      aw_valid = 1'b1;
      aw_ready = 1'b1;
    end
    @(negedge Clk_CI);
    set_handshake(1'b0);
    sweep_all();

    // Clear from FULL, then fresh traffic from index 0
    pulse_clear();
    sweep_all();
    run_traffic(5, 5);
    sweep_all();

    // Back-to-back reads, channel toggles every read
    for (int i = 0; i < 32; i++) begin
      issue_read({i[0], 6'(i >> 3), 2'(i >> 1)});
    end
    drain_reads();

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire
